// ==== ex_data_sram.sv ====
// byte-masked 64-bit synchronous data SRAM
`default_nettype none
`timescale 1ns/10ps

module ex_data_sram (
  input  logic                       i_clk,
  input  ex_pkg::sram_req_t          i_req,
  output logic [ex_pkg::WORD_WD-1:0] o_rdata
);

  logic [ex_pkg::WORD_WD-1:0]       mem [ex_pkg::SRAM_DEPTH];
  logic [ex_pkg::SRAM_INDEX_WD-1:0] index;

  assign index = i_req.addr[ex_pkg::SRAM_INDEX_WD+2:3];  // doubleword index

  always_ff @(posedge i_clk) begin
    if (i_req.wen) begin
      for (int b = 0; b < ex_pkg::SRAM_WMASK_WD; b++) begin
        if (i_req.wmask[b]) begin
          mem[index][b*8 +: 8] <= i_req.wdata[b*8 +: 8];
        end
      end
    end
  end

  // read port, word visible the cycle after the request
  always_ff @(posedge i_clk) begin
    if (i_req.ren) begin
      o_rdata <= mem[index];
    end
  end

endmodule

`default_nettype wire

// ==== ex_exu.sv ====
// operand selection, 64-bit ALU with word truncation, and CSR update logic
`default_nettype none
`timescale 1ns/10ps

module ex_exu (
  input  ex_pkg::ds_to_es_t          i_ex,
  output logic [ex_pkg::WORD_WD-1:0] o_alu_result,
  output logic [ex_pkg::WORD_WD-1:0] o_csr_result
);

  logic [ex_pkg::WORD_WD-1:0] src1;
  logic [ex_pkg::WORD_WD-1:0] src2;
  logic [ex_pkg::WORD_WD-1:0] shift_src;
  logic [5:0]                 shamt;
  logic [ex_pkg::WORD_WD-1:0] alu_full;
  logic [ex_pkg::WORD_WD-1:0] csr_src;

  always_comb begin
    src1 = i_ex.src1_sel ? i_ex.pc : i_ex.rs1data;  // auipc, jal
    case (i_ex.src2_sel)
      ex_pkg::SRC2_RS2:  src2 = i_ex.rs2data;
      ex_pkg::SRC2_IMM:  src2 = i_ex.imm;
      ex_pkg::SRC2_FOUR: src2 = 64'd4;               // link address
      default:           src2 = '0;
    endcase
  end

  // word shifts only see the low 32 bits; sraw needs the sign above them
  always_comb begin
    shamt = i_ex.word_cut ? {1'b0, src2[4:0]} : src2[5:0];
    if (i_ex.word_cut) begin
      shift_src = {{32{src1[31] & (i_ex.alu_op == ex_pkg::ALU_SRA)}}, src1[31:0]};
    end else begin
      shift_src = src1;
    end
  end

  always_comb begin
    case (i_ex.alu_op)
      ex_pkg::ALU_ADD:   alu_full = src1 + src2;
      ex_pkg::ALU_SUB:   alu_full = src1 - src2;
      ex_pkg::ALU_SLL:   alu_full = shift_src << shamt;
      ex_pkg::ALU_SLT:   alu_full = {63'd0, $signed(src1) < $signed(src2)};
      ex_pkg::ALU_SLTU:  alu_full = {63'd0, src1 < src2};
      ex_pkg::ALU_XOR:   alu_full = src1 ^ src2;
      ex_pkg::ALU_SRL:   alu_full = shift_src >> shamt;
      ex_pkg::ALU_SRA:   alu_full = $signed(shift_src) >>> shamt;
      ex_pkg::ALU_OR:    alu_full = src1 | src2;
      ex_pkg::ALU_AND:   alu_full = src1 & src2;
      ex_pkg::ALU_PASS2: alu_full = src2;
      default:           alu_full = '0;
    endcase
    if (i_ex.word_cut) begin
      o_alu_result = {{32{alu_full[31]}}, alu_full[31:0]};
    end else begin
      o_alu_result = alu_full;
    end
  end

  always_comb begin
    case (i_ex.csr_op)
      ex_pkg::CSR_RWI,
      ex_pkg::CSR_RSI,
      ex_pkg::CSR_RCI: csr_src = i_ex.imm;  // zimm, already zero extended
      default:         csr_src = i_ex.rs1data;
    endcase
    case (i_ex.csr_op)
      ex_pkg::CSR_RW,
      ex_pkg::CSR_RWI: o_csr_result = csr_src;
      ex_pkg::CSR_RS,
      ex_pkg::CSR_RSI: o_csr_result = i_ex.csrrdata | csr_src;
      ex_pkg::CSR_RC,
      ex_pkg::CSR_RCI: o_csr_result = i_ex.csrrdata & ~csr_src;
      default:         o_csr_result = i_ex.csrrdata;
    endcase
  end

endmodule

`default_nettype wire

// ==== ex_lsu_store.sv ====
// store byte mask and lane-shifted store data
`default_nettype none
`timescale 1ns/10ps

module ex_lsu_store (
  input  ex_pkg::mem_op_e                  i_mem_op,
  input  logic [2:0]                       i_addr_low,
  input  logic [ex_pkg::WORD_WD-1:0]       i_wdata,
  output logic [ex_pkg::SRAM_WMASK_WD-1:0] o_wmask,
  output logic [ex_pkg::WORD_WD-1:0]       o_wdata
);

  logic [ex_pkg::SRAM_WMASK_WD-1:0] size_mask;

  // bytes covered by the access, before moving to the lane
  always_comb begin
    case (i_mem_op)
      ex_pkg::MEM_B,
      ex_pkg::MEM_BU: size_mask = 8'h01;
      ex_pkg::MEM_H,
      ex_pkg::MEM_HU: size_mask = 8'h03;
      ex_pkg::MEM_W,
      ex_pkg::MEM_WU: size_mask = 8'h0f;
      default:        size_mask = 8'hff;
    endcase
  end

  always_comb begin
    o_wmask = size_mask << i_addr_low;
    o_wdata = i_wdata << {i_addr_low, 3'b000};  // byte offset to bit offset
  end

endmodule

`default_nettype wire

// ==== ex_mem_stage.sv ====
// memory stage: record register, load data hold, load extension and writeback record
`default_nettype none
`timescale 1ns/10ps

module ex_mem_stage (
  input  logic                       i_clk,
  input  logic                       i_reset,
  input  logic                       i_es_to_ms_valid,
  input  ex_pkg::es_to_ms_t          i_es_to_ms_bus,
  input  logic [ex_pkg::WORD_WD-1:0] i_rdata,
  input  logic                       i_wb_allowin,
  output logic                       o_ms_allowin,
  output logic                       o_wb_valid,
  output ex_pkg::wb_t                o_wb_bus
);

  logic                       ms_valid;
  logic                       ms_first;  // sram data is live this cycle
  ex_pkg::es_to_ms_t          ms_r;
  logic [ex_pkg::WORD_WD-1:0] rdata_hold;
  logic [ex_pkg::WORD_WD-1:0] rdata;
  logic [ex_pkg::WORD_WD-1:0] lane;
  logic [ex_pkg::WORD_WD-1:0] load_data;

  assign o_ms_allowin = !ms_valid || i_wb_allowin;
  assign o_wb_valid   = ms_valid;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ms_valid <= 1'b0;
      ms_first <= 1'b0;
    end else if (o_ms_allowin) begin
      ms_valid <= i_es_to_ms_valid;
      ms_first <= i_es_to_ms_valid;
    end else begin
      ms_first <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_es_to_ms_valid && o_ms_allowin) begin
      ms_r <= i_es_to_ms_bus;
    end
  end

  // keep the read word once the item stalls past its first cycle
  always_ff @(posedge i_clk) begin
    if (ms_first && !i_wb_allowin) begin
      rdata_hold <= i_rdata;
    end
  end

  assign rdata = ms_first ? i_rdata : rdata_hold;
  assign lane  = rdata >> {ms_r.addr_low, 3'b000};

  always_comb begin
    case (ms_r.mem_op)
      ex_pkg::MEM_B:  load_data = {{56{lane[7]}}, lane[7:0]};
      ex_pkg::MEM_H:  load_data = {{48{lane[15]}}, lane[15:0]};
      ex_pkg::MEM_W:  load_data = {{32{lane[31]}}, lane[31:0]};
      ex_pkg::MEM_BU: load_data = {56'd0, lane[7:0]};
      ex_pkg::MEM_HU: load_data = {48'd0, lane[15:0]};
      ex_pkg::MEM_WU: load_data = {32'd0, lane[31:0]};
      default:        load_data = lane;  // ld
    endcase
  end

  always_comb begin
    o_wb_bus.rd      = ms_r.rd;
    o_wb_bus.gpr_wen = ms_r.gpr_wen;
    if (ms_r.mem_ren) begin
      o_wb_bus.gpr_wdata = load_data;
    end else if (ms_r.csr_inst) begin
      o_wb_bus.gpr_wdata = ms_r.csrrdata;  // old csr value to rd
    end else begin
      o_wb_bus.gpr_wdata = ms_r.alu_result;
    end
    o_wb_bus.csr       = ms_r.csr;
    o_wb_bus.csr_wen   = ms_r.csr_wen;
    o_wb_bus.csr_wdata = ms_r.csr_result;
    o_wb_bus.ebreak    = ms_r.ebreak;
    o_wb_bus.invalid   = ms_r.invalid;
  end

endmodule

`default_nettype wire

// ==== ex_mem_top.sv ====
// top of the execute and memory stages with the data SRAM
`default_nettype none
`timescale 1ns/10ps

module ex_mem_top (
  input  logic              i_clk,
  input  logic              i_reset,
  input  logic              i_ds_valid,
  input  ex_pkg::ds_to_es_t i_ds_bus,
  input  logic              i_wb_allowin,
  output logic              o_es_allowin,
  output logic              o_wb_valid,
  output ex_pkg::wb_t       o_wb_bus,
  output ex_pkg::bypass_t   o_bypass,
  output logic              o_load_sel
);

  logic                       ms_allowin;
  logic                       es_to_ms_valid;
  ex_pkg::es_to_ms_t          es_to_ms_bus;
  ex_pkg::sram_req_t          sram_req;
  logic [ex_pkg::WORD_WD-1:0] sram_rdata;

  ex_stage u_ex_stage (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_ds_valid       (i_ds_valid),
    .i_ds_bus         (i_ds_bus),
    .i_ms_allowin     (ms_allowin),
    .o_es_allowin     (o_es_allowin),
    .o_es_to_ms_valid (es_to_ms_valid),
    .o_es_to_ms_bus   (es_to_ms_bus),
    .o_sram_req       (sram_req),
    .o_load_sel       (o_load_sel),
    .o_bypass         (o_bypass)
  );

  ex_data_sram u_data_sram (
    .i_clk   (i_clk),
    .i_req   (sram_req),
    .o_rdata (sram_rdata)
  );

  ex_mem_stage u_mem_stage (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_es_to_ms_valid (es_to_ms_valid),
    .i_es_to_ms_bus   (es_to_ms_bus),
    .i_rdata          (sram_rdata),
    .i_wb_allowin     (i_wb_allowin),
    .o_ms_allowin     (ms_allowin),
    .o_wb_valid       (o_wb_valid),
    .o_wb_bus         (o_wb_bus)
  );

endmodule

`default_nettype wire

// ==== ex_pkg.sv ====
// widths, op codes and stage records shared by the execute and memory stages
`default_nettype none

package ex_pkg;

  localparam int WORD_WD       = 64;
  localparam int GPR_ADDR_WD   = 5;
  localparam int CSR_ADDR_WD   = 12;
  localparam int SRAM_ADDR_WD  = 32;
  localparam int SRAM_WMASK_WD = 8;
  localparam int SRAM_DEPTH    = 256;   // doublewords
  localparam int SRAM_INDEX_WD = $clog2(SRAM_DEPTH);

  typedef enum logic [4:0] {
    ALU_ADD   = 5'd0,
    ALU_SUB   = 5'd1,
    ALU_SLL   = 5'd2,
    ALU_SLT   = 5'd3,
    ALU_SLTU  = 5'd4,
    ALU_XOR   = 5'd5,
    ALU_SRL   = 5'd6,
    ALU_SRA   = 5'd7,
    ALU_OR    = 5'd8,
    ALU_AND   = 5'd9,
    ALU_PASS2 = 5'd10  // lui
  } alu_op_e;

  typedef enum logic [2:0] {
    MEM_B  = 3'd0,
    MEM_H  = 3'd1,
    MEM_W  = 3'd2,
    MEM_D  = 3'd3,
    MEM_BU = 3'd4,
    MEM_HU = 3'd5,
    MEM_WU = 3'd6
  } mem_op_e;

  // bit 2 marks the immediate forms
  typedef enum logic [2:0] {
    CSR_RW  = 3'd1,
    CSR_RS  = 3'd2,
    CSR_RC  = 3'd3,
    CSR_RWI = 3'd5,
    CSR_RSI = 3'd6,
    CSR_RCI = 3'd7
  } csr_op_e;

  typedef enum logic [1:0] {
    SRC2_RS2  = 2'd0,
    SRC2_IMM  = 2'd1,
    SRC2_FOUR = 2'd2
  } src2_sel_e;

  typedef struct packed {
    logic                   load_inst;
    logic [WORD_WD-1:0]     rs1data;
    logic [WORD_WD-1:0]     rs2data;
    logic [WORD_WD-1:0]     csrrdata;
    logic [WORD_WD-1:0]     imm;
    logic [WORD_WD-1:0]     pc;
    logic                   src1_sel;   // pc when set
    src2_sel_e              src2_sel;
    logic                   word_cut;
    alu_op_e                alu_op;
    logic [GPR_ADDR_WD-1:0] rd;
    logic [CSR_ADDR_WD-1:0] csr;
    logic                   gpr_wen;
    logic                   csr_wen;
    logic                   mem_ren;
    logic                   mem_wen;
    mem_op_e                mem_op;
    logic                   csr_inst;
    csr_op_e                csr_op;
    logic                   ebreak;
    logic                   invalid;
  } ds_to_es_t;

  typedef struct packed {
    logic [GPR_ADDR_WD-1:0] rd;
    logic [CSR_ADDR_WD-1:0] csr;
    logic                   gpr_wen;
    logic                   csr_wen;
    logic                   mem_ren;
    mem_op_e                mem_op;
    logic                   csr_inst;
    logic [WORD_WD-1:0]     csrrdata;
    logic [WORD_WD-1:0]     alu_result;
    logic [WORD_WD-1:0]     csr_result;
    logic [2:0]             addr_low;
    logic                   ebreak;
    logic                   invalid;
  } es_to_ms_t;

  typedef struct packed {
    logic [SRAM_ADDR_WD-1:0]  addr;
    logic                     ren;
    logic                     wen;
    logic [SRAM_WMASK_WD-1:0] wmask;
    logic [WORD_WD-1:0]       wdata;
  } sram_req_t;

  typedef struct packed {
    logic                   valid;
    logic [GPR_ADDR_WD-1:0] rd;
    logic [WORD_WD-1:0]     gpr_data;
    logic [CSR_ADDR_WD-1:0] csr;
    logic [WORD_WD-1:0]     csr_data;
  } bypass_t;

  typedef struct packed {
    logic [GPR_ADDR_WD-1:0] rd;
    logic                   gpr_wen;
    logic [WORD_WD-1:0]     gpr_wdata;
    logic [CSR_ADDR_WD-1:0] csr;
    logic                   csr_wen;
    logic [WORD_WD-1:0]     csr_wdata;
    logic                   ebreak;
    logic                   invalid;
  } wb_t;

endpackage

`default_nettype wire

// ==== ex_stage.sv ====
// execute stage: pipeline register, handshake, SRAM request, bypass and load flag
`default_nettype none
`timescale 1ns/10ps

module ex_stage (
  input  logic                     i_clk,
  input  logic                     i_reset,
  input  logic                     i_ds_valid,
  input  ex_pkg::ds_to_es_t        i_ds_bus,
  input  logic                     i_ms_allowin,
  output logic                     o_es_allowin,
  output logic                     o_es_to_ms_valid,
  output ex_pkg::es_to_ms_t        o_es_to_ms_bus,
  output ex_pkg::sram_req_t        o_sram_req,
  output logic                     o_load_sel,
  output ex_pkg::bypass_t          o_bypass
);

  logic                       es_valid;
  ex_pkg::ds_to_es_t          es_r;
  logic [ex_pkg::WORD_WD-1:0] alu_result;
  logic [ex_pkg::WORD_WD-1:0] csr_result;
  logic                       es_go;   // item moves to memory at this edge

  assign o_es_allowin     = !es_valid || i_ms_allowin;  // exu never stalls
  assign o_es_to_ms_valid = es_valid;
  assign es_go            = es_valid && i_ms_allowin;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      es_valid <= 1'b0;
    end else if (o_es_allowin) begin
      es_valid <= i_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ds_valid && o_es_allowin) begin
      es_r <= i_ds_bus;
    end
  end

  ex_exu u_exu (
    .i_ex         (es_r),
    .o_alu_result (alu_result),
    .o_csr_result (csr_result)
  );

  ex_lsu_store u_lsu_store (
    .i_mem_op   (es_r.mem_op),
    .i_addr_low (alu_result[2:0]),
    .i_wdata    (es_r.rs2data),
    .o_wmask    (o_sram_req.wmask),
    .o_wdata    (o_sram_req.wdata)
  );

  // request only on the move, so a stall never repeats a read
  assign o_sram_req.addr = alu_result[ex_pkg::SRAM_ADDR_WD-1:0];
  assign o_sram_req.ren  = es_go && es_r.mem_ren;
  assign o_sram_req.wen  = es_go && es_r.mem_wen;

  always_comb begin
    o_es_to_ms_bus.rd         = es_r.rd;
    o_es_to_ms_bus.csr        = es_r.csr;
    o_es_to_ms_bus.gpr_wen    = es_r.gpr_wen;
    o_es_to_ms_bus.csr_wen    = es_r.csr_wen;
    o_es_to_ms_bus.mem_ren    = es_r.mem_ren;
    o_es_to_ms_bus.mem_op     = es_r.mem_op;
    o_es_to_ms_bus.csr_inst   = es_r.csr_inst;
    o_es_to_ms_bus.csrrdata   = es_r.csrrdata;
    o_es_to_ms_bus.alu_result = alu_result;
    o_es_to_ms_bus.csr_result = csr_result;
    o_es_to_ms_bus.addr_low   = alu_result[2:0];
    o_es_to_ms_bus.ebreak     = es_r.ebreak;
    o_es_to_ms_bus.invalid    = es_r.invalid;
  end

  assign o_load_sel = es_valid && es_r.load_inst;  // decode stalls on this

  // disabled fields read as zero
  always_comb begin
    o_bypass.valid    = es_valid;
    o_bypass.rd       = (es_valid && es_r.gpr_wen) ? es_r.rd : '0;
    o_bypass.gpr_data = '0;
    if (es_valid && es_r.gpr_wen) begin
      o_bypass.gpr_data = es_r.csr_inst ? es_r.csrrdata : alu_result;
    end
    o_bypass.csr      = (es_valid && es_r.csr_wen) ? es_r.csr : '0;
    o_bypass.csr_data = (es_valid && es_r.csr_wen) ? csr_result : '0;
  end

endmodule

`default_nettype wire

// ==== list.f ====
ex_pkg.sv
ex_exu.sv
ex_lsu_store.sv
ex_stage.sv
ex_data_sram.sv
ex_mem_stage.sv
ex_mem_top.sv
tb_ex_mem_top.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary -Wno-fatal --top-module tb_ex_mem_top -f list.f -Mdir obj_dir -o tb_sim \
  > build.log 2>&1 &&
./obj_dir/tb_sim > sim.log 2>&1 || { cat build.log sim.log 2>/dev/null; echo "FAIL"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "FAIL"; exit 1; }
echo "PASS"

// ==== tb_ex_mem_top.sv ====
// table-driven testbench for the execute and memory stages with random writeback stalls
`default_nettype none
`timescale 1ns/10ps

module tb_ex_mem_top;

  logic              i_clk;
  logic              i_reset;
  logic              i_ds_valid;
  ex_pkg::ds_to_es_t i_ds_bus;
  logic              i_wb_allowin;
  logic              o_es_allowin;
  logic              o_wb_valid;
  ex_pkg::wb_t       o_wb_bus;
  ex_pkg::bypass_t   o_bypass;
  logic              o_load_sel;

  ex_pkg::ds_to_es_t ds_tbl[$];
  ex_pkg::wb_t       wb_tbl[$];
  logic [31:0]       lfsr;

  ex_mem_top dut_i (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_ds_valid   (i_ds_valid),
    .i_ds_bus     (i_ds_bus),
    .i_wb_allowin (i_wb_allowin),
    .o_es_allowin (o_es_allowin),
    .o_wb_valid   (o_wb_valid),
    .o_wb_bus     (o_wb_bus),
    .o_bypass     (o_bypass),
    .o_load_sel   (o_load_sel)
  );

  always #4 i_clk = ~i_clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic expect_equal(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    assert (got === exp) else begin
      $display("mismatch %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  // a few entries carry ebreak or invalid
  function automatic ex_pkg::ds_to_es_t blank_ds();
    ex_pkg::ds_to_es_t d;
    d = '0;
    d.rd = 5'((ds_tbl.size() % 31) + 1);
    d.gpr_wen = 1'b1;
    d.ebreak  = (ds_tbl.size() % 4) == 1;
    d.invalid = (ds_tbl.size() % 5) == 3;
    return d;
  endfunction

  // expected record: gpr and csr data only matter when enabled
  task automatic append_pair(input ex_pkg::ds_to_es_t d, input logic [63:0] gpr,
                             input logic [63:0] csr);
    ex_pkg::wb_t w;
    w = '0;
    w.rd        = d.rd;
    w.gpr_wen   = d.gpr_wen;
    w.gpr_wdata = d.gpr_wen ? gpr : '0;
    w.csr       = d.csr;
    w.csr_wen   = d.csr_wen;
    w.csr_wdata = d.csr_wen ? csr : '0;
    w.ebreak    = d.ebreak;
    w.invalid   = d.invalid;
    ds_tbl.push_back(d);
    wb_tbl.push_back(w);
  endtask

  task automatic alu_entry(input ex_pkg::alu_op_e op, input ex_pkg::src2_sel_e sel,
                           input logic wc, input logic [63:0] rs1, input logic [63:0] op2,
                           input logic [63:0] exp);
    ex_pkg::ds_to_es_t d;
    d = blank_ds();
    d.alu_op   = op;
    d.src2_sel = sel;
    d.word_cut = wc;
    d.rs1data  = rs1;
    d.rs2data  = op2;
    d.imm      = op2;
    append_pair(d, exp, '0);
  endtask

  task automatic pc_entry(input ex_pkg::src2_sel_e sel, input logic [63:0] pc,
                          input logic [63:0] imm, input logic [63:0] exp);
    ex_pkg::ds_to_es_t d;
    d = blank_ds();
    d.src1_sel = 1'b1;
    d.src2_sel = sel;
    d.pc       = pc;
    d.imm      = imm;
    d.rs1data  = 64'hdead;  // must be ignored
    append_pair(d, exp, '0);
  endtask

  // csrrdata f0, rs1 0f, zimm 11
  task automatic csr_entry(input ex_pkg::csr_op_e op, input logic [63:0] exp_csr);
    ex_pkg::ds_to_es_t d;
    d = blank_ds();
    d.csr_inst = 1'b1;
    d.csr_wen  = 1'b1;
    d.csr_op   = op;
    d.csr      = 12'h300 + 12'(ds_tbl.size());
    d.csrrdata = 64'hf0;
    d.rs1data  = 64'h0f;
    d.imm      = 64'h11;
    append_pair(d, 64'hf0, exp_csr);
  endtask

  task automatic store_entry(input ex_pkg::mem_op_e op, input logic [63:0] addr,
                             input logic [63:0] data);
    ex_pkg::ds_to_es_t d;
    d = blank_ds();
    d.rd       = '0;
    d.gpr_wen  = 1'b0;
    d.mem_wen  = 1'b1;
    d.mem_op   = op;
    d.src2_sel = ex_pkg::SRC2_IMM;
    d.rs1data  = 64'h100;
    d.imm      = addr - 64'h100;
    d.rs2data  = data;
    append_pair(d, '0, '0);
  endtask

  task automatic load_entry(input ex_pkg::mem_op_e op, input logic [63:0] addr,
                            input logic [63:0] exp);
    ex_pkg::ds_to_es_t d;
    d = blank_ds();
    d.load_inst = 1'b1;
    d.mem_ren   = 1'b1;
    d.mem_op    = op;
    d.src2_sel  = ex_pkg::SRC2_IMM;
    d.rs1data   = 64'h100;
    d.imm       = addr - 64'h100;
    append_pair(d, exp, '0);
  endtask

  task automatic build_table();
    logic [63:0] a;
    a = 64'hffff_ffff_8000_0010;
    alu_entry(ex_pkg::ALU_ADD,   ex_pkg::SRC2_RS2, 0, a, 64'h24, 64'hffff_ffff_8000_0034);
    alu_entry(ex_pkg::ALU_SUB,   ex_pkg::SRC2_RS2, 0, a, 64'h24, 64'hffff_ffff_7fff_ffec);
    alu_entry(ex_pkg::ALU_SLL,   ex_pkg::SRC2_IMM, 0, a, 64'h4, 64'hffff_fff8_0000_0100);
    alu_entry(ex_pkg::ALU_SLT,   ex_pkg::SRC2_RS2, 0, a, 64'h24, 64'h1);
    alu_entry(ex_pkg::ALU_SLTU,  ex_pkg::SRC2_RS2, 0, a, 64'h24, 64'h0);
    alu_entry(ex_pkg::ALU_XOR,   ex_pkg::SRC2_IMM, 0, a, 64'hffff_ffff, 64'hffff_ffff_7fff_ffef);
    alu_entry(ex_pkg::ALU_SRL,   ex_pkg::SRC2_IMM, 0, a, 64'h8, 64'h00ff_ffff_ff80_0000);
    alu_entry(ex_pkg::ALU_SRA,   ex_pkg::SRC2_IMM, 0, a, 64'h8, 64'hffff_ffff_ff80_0000);
    alu_entry(ex_pkg::ALU_OR,    ex_pkg::SRC2_RS2, 0, a, 64'h24, 64'hffff_ffff_8000_0034);
    alu_entry(ex_pkg::ALU_AND,   ex_pkg::SRC2_IMM, 0, a, 64'hf0, 64'h10);
    alu_entry(ex_pkg::ALU_PASS2, ex_pkg::SRC2_IMM, 0, a, 64'h1234_5000, 64'h1234_5000);
    pc_entry(ex_pkg::SRC2_FOUR, 64'h8000_1000, 64'h0, 64'h8000_1004);
    pc_entry(ex_pkg::SRC2_IMM, 64'h8000_1000, 64'hffff_ffff_ffff_fff0, 64'h8000_0ff0);
    // word forms, sign extended from bit 31
    alu_entry(ex_pkg::ALU_ADD, ex_pkg::SRC2_IMM, 1, 64'h7fff_ffff, 64'h1, 64'hffff_ffff_8000_0000);
    alu_entry(ex_pkg::ALU_SUB, ex_pkg::SRC2_RS2, 1, 64'h1_0000_0005, 64'h6, '1);
    alu_entry(ex_pkg::ALU_SRA, ex_pkg::SRC2_IMM, 1, 64'h8000_0000, 64'h4, 64'hffff_ffff_f800_0000);
    alu_entry(ex_pkg::ALU_SRL, ex_pkg::SRC2_IMM, 1, 64'h8000_0000, 64'h4, 64'h0800_0000);
    alu_entry(ex_pkg::ALU_SLL, ex_pkg::SRC2_IMM, 1, 64'h1, 64'd31, 64'hffff_ffff_8000_0000);
    csr_entry(ex_pkg::CSR_RW,  64'h0f);
    csr_entry(ex_pkg::CSR_RS,  64'hff);
    csr_entry(ex_pkg::CSR_RC,  64'hf0);
    csr_entry(ex_pkg::CSR_RWI, 64'h11);
    csr_entry(ex_pkg::CSR_RSI, 64'hf1);
    csr_entry(ex_pkg::CSR_RCI, 64'he0);
    // doubleword at 0x100 ends as beef_c3d4_e5f6_a511
    store_entry(ex_pkg::MEM_D, 64'h100, 64'h8877_6655_4433_2211);
    store_entry(ex_pkg::MEM_B, 64'h101, 64'hffff_ffa5);
    store_entry(ex_pkg::MEM_H, 64'h106, 64'h1234_beef);
    store_entry(ex_pkg::MEM_W, 64'h102, 64'hc3d4_e5f6);
    load_entry(ex_pkg::MEM_D,  64'h100, 64'hbeef_c3d4_e5f6_a511);
    load_entry(ex_pkg::MEM_B,  64'h101, 64'hffff_ffff_ffff_ffa5);
    load_entry(ex_pkg::MEM_BU, 64'h101, 64'ha5);
    load_entry(ex_pkg::MEM_H,  64'h106, 64'hffff_ffff_ffff_beef);
    load_entry(ex_pkg::MEM_HU, 64'h106, 64'hbeef);
    load_entry(ex_pkg::MEM_W,  64'h104, 64'hffff_ffff_beef_c3d4);
    load_entry(ex_pkg::MEM_WU, 64'h104, 64'hbeef_c3d4);
    load_entry(ex_pkg::MEM_W,  64'h100, 64'hffff_ffff_e5f6_a511);
  endtask

  task automatic compare_wb(input ex_pkg::wb_t got, input ex_pkg::wb_t exp);
    expect_equal("o_wb_bus.rd", 64'(got.rd), 64'(exp.rd));
    expect_equal("o_wb_bus.gpr_wen", 64'(got.gpr_wen), 64'(exp.gpr_wen));
    if (exp.gpr_wen) expect_equal("o_wb_bus.gpr_wdata", got.gpr_wdata, exp.gpr_wdata);
    expect_equal("o_wb_bus.csr", 64'(got.csr), 64'(exp.csr));
    expect_equal("o_wb_bus.csr_wen", 64'(got.csr_wen), 64'(exp.csr_wen));
    if (exp.csr_wen) expect_equal("o_wb_bus.csr_wdata", got.csr_wdata, exp.csr_wdata);
    expect_equal("o_wb_bus.ebreak", 64'(got.ebreak), 64'(exp.ebreak));
    expect_equal("o_wb_bus.invalid", 64'(got.invalid), 64'(exp.invalid));
  endtask

  // bypass mirrors the entry sitting in execute
  task automatic verify_bypass(input int last_acc);
    ex_pkg::ds_to_es_t d;
    ex_pkg::wb_t       w;
    if (!o_bypass.valid) begin
      expect_equal("o_load_sel", 64'(o_load_sel), 64'h0);
    end else begin
      assert (last_acc >= 0) else begin
        $display("bypass valid before any entry was accepted");
        abort_run();
      end
      d = ds_tbl[last_acc];
      w = wb_tbl[last_acc];
      expect_equal("o_load_sel", 64'(o_load_sel), 64'(d.load_inst));
      expect_equal("o_bypass.rd", 64'(o_bypass.rd), d.gpr_wen ? 64'(d.rd) : 64'h0);
      if (!d.load_inst) expect_equal("o_bypass.gpr_data", o_bypass.gpr_data, w.gpr_wdata);
      expect_equal("o_bypass.csr", 64'(o_bypass.csr), d.csr_wen ? 64'(d.csr) : 64'h0);
      expect_equal("o_bypass.csr_data", o_bypass.csr_data, w.csr_wdata);
    end
  endtask

  initial begin
    int          issue_idx;
    int          wb_idx;
    int          last_acc;
    int          cycles;
    int          wait_cnt;
    logic        es_take;
    logic        wb_take;
    logic        wb_stall;
    ex_pkg::wb_t seen_wb;
    i_clk        = 1'b0;
    i_reset      = 1'b1;
    i_ds_valid   = 1'b0;
    i_ds_bus     = '0;
    i_wb_allowin = 1'b0;
    lfsr         = 32'h535;
    issue_idx    = 0;
    wb_idx       = 0;
    last_acc     = -1;
    cycles       = 0;
    wait_cnt     = 0;
    es_take      = 1'b0;
    wb_take      = 1'b0;
    wb_stall     = 1'b0;
    seen_wb      = '0;
    build_table();
    repeat (3) @(negedge i_clk);
    i_reset = 1'b0;
    @(negedge i_clk);
    expect_equal("o_wb_valid", 64'(o_wb_valid), 64'h0);
    expect_equal("o_load_sel", 64'(o_load_sel), 64'h0);
    expect_equal("o_bypass.valid", 64'(o_bypass.valid), 64'h0);
    expect_equal("o_es_allowin", 64'(o_es_allowin), 64'h1);
    while (wb_idx < wb_tbl.size()) begin
      if (cycles > 4000) begin
        $display("writeback records stopped arriving");
        abort_run();
      end
      i_ds_valid = issue_idx < ds_tbl.size();
      if (i_ds_valid) i_ds_bus = ds_tbl[issue_idx];
      i_wb_allowin = lfsr[0];
      lfsr = lfsr_next(lfsr);
      // handshake as seen by the rising edge
      @(posedge i_clk);
      es_take  = i_ds_valid && o_es_allowin;
      wb_take  = o_wb_valid && i_wb_allowin;
      wb_stall = o_wb_valid && !i_wb_allowin;
      seen_wb  = o_wb_bus;
      @(negedge i_clk);
      cycles++;
      if (wb_take) begin
        compare_wb(seen_wb, wb_tbl[wb_idx]);
        wb_idx++;
      end
      if (wb_stall) begin
        assert (o_wb_valid && o_wb_bus === seen_wb) else begin
          $display("writeback record changed while stalled");
          abort_run();
        end
      end
      if (es_take) begin
        last_acc = issue_idx;
        issue_idx++;
        wait_cnt = 0;
      end else if (i_ds_valid) begin
        wait_cnt++;
        if (wait_cnt > 100) begin
          $display("entry %0d was not accepted in time", issue_idx);
          abort_run();
        end
      end
      verify_bypass(last_acc);
    end
    if (!o_wb_valid) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("extra writeback record after the table ended");
      abort_run();
    end
  end

endmodule

`default_nettype wire
